// File: sim.f
source/nabp_pkg.sv
source/nabp_ctrl_if.sv
source/nabp_state_control.sv
source/nabp_shifter.sv
source/nabp_filter_mapper.sv
source/nabp_pixel_accumulator.sv
source/nabp_line_unit.sv
tb/tb_nabp_line_unit.sv

// File: Bender.yml
package:
  name: nabp_line_unit

sources:
  - files:
      - source/nabp_pkg.sv
      - source/nabp_ctrl_if.sv
      - source/nabp_state_control.sv
      - source/nabp_shifter.sv
      - source/nabp_filter_mapper.sv
      - source/nabp_pixel_accumulator.sv
      - source/nabp_line_unit.sv
  - target: test
    files:
      - tb/tb_nabp_line_unit.sv

// File: tb/tb_nabp_line_unit.sv
`timescale 1ns/100ps

module tb_nabp_line_unit;

    localparam int WAIT_LIMIT = 100;
    localparam int DRAIN_CYCLES = nabp_pkg::FILL_COUNT + nabp_pkg::IMAGE_SIZE + 4;
    localparam int SAMPLE_DEPTH = 16;

    logic clk;
    logic reset_n;
    logic start;
    logic [nabp_pkg::ACCU_WIDTH-1:0] step;
    logic accumulate_clear;
    nabp_pkg::sample_t sample_in;
    nabp_pkg::pixel_addr_t rd_addr;
    logic sample_take;
    logic busy;
    logic line_done;
    nabp_pkg::pixel_t rd_data;

    nabp_pkg::sample_t angle_samples [SAMPLE_DEPTH];
    nabp_pkg::pixel_t model [nabp_pkg::IMAGE_SIZE];
    int sample_idx;
    int take_count;
    int value_errors;
    int timeout_errors;
    int seed;

    nabp_line_unit i_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .start            (start),
        .step             (step),
        .accumulate_clear (accumulate_clear),
        .sample_in        (sample_in),
        .rd_addr          (rd_addr),
        .sample_take      (sample_take),
        .busy             (busy),
        .line_done        (line_done),
        .rd_data          (rd_data)
    );

    always #5 clk = ~clk;

    // sample source that moves on after every cycle with a take
    always @(posedge clk)
    begin
        #1;
        sample_in = angle_samples[sample_idx];
        if (sample_take === 1'b1)
        begin
            take_count++;
            if (sample_idx < SAMPLE_DEPTH - 1)
                sample_idx++;
        end
    end

    task automatic check_pixel(input nabp_pkg::pixel_t actual, input nabp_pkg::pixel_t expected,
                               input string what);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[FAIL] %0t: %s read %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected)
        begin
            value_errors++;
            $display("[FAIL] %0t: %s counted %0d, expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            value_errors++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    task automatic print_summary();
        $display("summary: %0d value errors, %0d timeouts", value_errors, timeout_errors);
    endtask

    task automatic load_ramp(input int base, input int stride);
        for (int i = 0; i < SAMPLE_DEPTH; i++)
        begin
            angle_samples[i] = nabp_pkg::sample_t'(base + i * stride);
        end
    endtask

    // pixel k gets sample floor(k * frac / 256) of the angle
    task automatic update_model(input logic [nabp_pkg::ACCU_WIDTH-1:0] step_word);
        int frac;
        frac = step_word[nabp_pkg::ACCU_FRAC_BITS-1:0];
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            model[k] = model[k] + nabp_pkg::pixel_t'(angle_samples[(k * frac) / 256]);
        end
    endtask

    task automatic check_all_pixels(input string what);
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            @(posedge clk);
            #1;
            rd_addr = nabp_pkg::pixel_addr_t'(k);
            @(negedge clk);
            check_pixel(rd_data, model[k], $sformatf("%s pixel %0d", what, k));
        end
    endtask

    task automatic clear_pixels();
        @(posedge clk);
        #1;
        accumulate_clear = 1'b1;
        @(posedge clk);
        #1;
        accumulate_clear = 1'b0;
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            model[k] = '0;
        end
    endtask

    // restart_at below zero means no second start pulse
    task automatic run_angle(input logic [nabp_pkg::ACCU_WIDTH-1:0] step_word,
                             input int restart_at);
        int cycles;
        int done_count;
        int expected_takes;
        expected_takes = nabp_pkg::FILL_COUNT
            + ((nabp_pkg::IMAGE_SIZE - 1) * step_word[nabp_pkg::ACCU_FRAC_BITS-1:0]) / 256;
        @(posedge clk);
        #1;
        sample_idx = 0;
        take_count = 0;
        @(posedge clk);
        #1;
        start = 1'b1;
        step = step_word;
        cycles = 0;
        while (line_done !== 1'b1 && cycles < WAIT_LIMIT)
        begin
            @(posedge clk);
            #1;
            start = (cycles == restart_at);
            cycles++;
            // busy covers the whole line and falls with line_done
            if (line_done === 1'b1)
                check_flag(busy, 1'b0, "busy at line_done");
            else
                check_flag(busy, 1'b1, "busy during line");
        end
        start = 1'b0;
        if (line_done !== 1'b1)
        begin
            timeout_errors++;
            $display("line_done never came for step %03h within %0d cycles",
                     step_word, WAIT_LIMIT);
            print_summary();
            $display("TEST RESULT: FAIL");
            $finish;
        end
        // watch for a stray second line and let the last pixel add land
        done_count = 1;
        repeat (DRAIN_CYCLES)
        begin
            @(posedge clk);
            #1;
            if (line_done === 1'b1)
                done_count++;
        end
        check_count(done_count, 1, "line_done pulses");
        check_count(take_count, expected_takes, $sformatf("samples taken, step %03h", step_word));
        check_flag(busy, 1'b0, "busy after line");
        update_model(step_word);
    endtask

    task automatic reset_values();
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(line_done, 1'b0, "line_done after reset");
        check_flag(sample_take, 1'b0, "sample_take after reset");
        check_all_pixels("reset");
    endtask

    task automatic step_zero_angle();
        load_ramp(17, 3);
        run_angle('0, -1);
        check_all_pixels("step zero");
    endtask

    task automatic fractional_step_angles();
        load_ramp(5, 7);
        run_angle(12'h080, -1);
        check_all_pixels("step 0.5");
        load_ramp(40, 9);
        run_angle(12'h0C0, -1);
        check_all_pixels("step 0.75");
    endtask

    task automatic two_angles_and_clear();
        clear_pixels();
        load_ramp(200, 13);
        run_angle(12'h055, -1);
        load_ramp(3, 29);
        run_angle(12'h0E1, -1);
        check_all_pixels("two angles");
        clear_pixels();
        check_all_pixels("after clear");
    endtask

    // integer bits of the step are dropped by the controller
    task automatic restart_ignored_while_busy();
        load_ramp(100, 11);
        run_angle(12'h5C0, 3);
        check_all_pixels("restart while busy");
    endtask

    // high samples so the 16-bit sums wrap over 320 angles
    task automatic random_angle_sums();
        logic [nabp_pkg::ACCU_WIDTH-1:0] step_word;
        clear_pixels();
        for (int i = 0; i < 20; i++)
        begin
            step_word = nabp_pkg::ACCU_WIDTH'($random(seed));
            repeat (16)
            begin
                for (int j = 0; j < SAMPLE_DEPTH; j++)
                begin
                    angle_samples[j] = 8'hE0 | nabp_pkg::sample_t'($random(seed) & 31);
                end
                run_angle(step_word, -1);
            end
        end
        check_all_pixels("random angles");
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        start = 1'b0;
        step = '0;
        accumulate_clear = 1'b0;
        sample_in = '0;
        rd_addr = '0;
        seed = 32'h8f2e74eb;
        value_errors = 0;
        timeout_errors = 0;
        sample_idx = 0;
        take_count = 0;
        load_ramp(0, 0);
        for (int k = 0; k < nabp_pkg::IMAGE_SIZE; k++)
        begin
            model[k] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;
        reset_values();
        step_zero_angle();
        fractional_step_angles();
        two_angles_and_clear();
        restart_ignored_while_busy();
        random_angle_sums();
        print_summary();
        if (value_errors == 0 && timeout_errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: source/nabp_line_unit.sv
`timescale 1ns/100ps

module nabp_line_unit (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic [nabp_pkg::ACCU_WIDTH-1:0] step,
    input  logic accumulate_clear,
    input  nabp_pkg::sample_t sample_in,
    input  nabp_pkg::pixel_addr_t rd_addr,
    output logic sample_take,
    output logic busy,
    output logic line_done,
    output nabp_pkg::pixel_t rd_data
);

    logic shift_en;
    logic pixel_valid;
    nabp_pkg::sample_t head_sample;

    nabp_ctrl_if ctrl_if ();

    // producer
    nabp_state_control i_state_control (
        .clk       (clk),
        .reset_n   (reset_n),
        .start     (start),
        .step      (step),
        .busy      (busy),
        .line_done (line_done),
        .ctrl      (ctrl_if.controller)
    );

    // sequencing between mapper and pixels
    nabp_shifter i_shifter (
        .clk         (clk),
        .reset_n     (reset_n),
        .ctrl        (ctrl_if.shifter),
        .shift_en    (shift_en),
        .pixel_valid (pixel_valid)
    );

    // sample window
    nabp_filter_mapper i_filter_mapper (
        .clk         (clk),
        .reset_n     (reset_n),
        .shift_en    (shift_en),
        .sample_in   (sample_in),
        .head_sample (head_sample)
    );

    // consumer
    nabp_pixel_accumulator i_pixel_accumulator (
        .clk              (clk),
        .reset_n          (reset_n),
        .pixel_valid      (pixel_valid),
        .head_sample      (head_sample),
        .accumulate_clear (accumulate_clear),
        .busy             (busy),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data)
    );

    // the source must present a new sample whenever the window shifts
    assign sample_take = shift_en;

endmodule

// File: source/nabp_pixel_accumulator.sv
`timescale 1ns/100ps

module nabp_pixel_accumulator (
    input  logic clk,
    input  logic reset_n,
    input  logic pixel_valid,
    input  nabp_pkg::sample_t head_sample,
    input  logic accumulate_clear,
    input  logic busy,
    input  nabp_pkg::pixel_addr_t rd_addr,
    output nabp_pkg::pixel_t rd_data
);

    nabp_pkg::pixel_t pixels [nabp_pkg::IMAGE_SIZE];
    nabp_pkg::pixel_addr_t pixel_idx;
    logic valid_d;

    // one cycle late, so the mapper shift for this pixel has landed
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            valid_d <= 1'b0;
            pixel_idx <= '0;
        end
        else
        begin
            valid_d <= pixel_valid;
            if (valid_d)
            begin
                if (pixel_idx == nabp_pkg::pixel_addr_t'(nabp_pkg::IMAGE_SIZE - 1))
                    pixel_idx <= '0;
                else
                    pixel_idx <= pixel_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n || (accumulate_clear && !busy))
        begin
            for (int i = 0; i < nabp_pkg::IMAGE_SIZE; i++)
            begin
                pixels[i] <= '0;
            end
        end
        else if (valid_d)
        begin
            // sums wrap at the pixel width
            pixels[pixel_idx] <= pixels[pixel_idx] + nabp_pkg::pixel_t'(head_sample);
        end
    end

    assign rd_data = pixels[rd_addr];

endmodule

// File: source/nabp_filter_mapper.sv
`timescale 1ns/100ps

module nabp_filter_mapper (
    input  logic clk,
    input  logic reset_n,
    input  logic shift_en,
    input  nabp_pkg::sample_t sample_in,
    output nabp_pkg::sample_t head_sample
);

    // entry 0 is the head, the oldest sample still kept
    nabp_pkg::sample_t window [nabp_pkg::FILL_COUNT];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            for (int i = 0; i < nabp_pkg::FILL_COUNT; i++)
            begin
                window[i] <= '0;
            end
        end
        else if (shift_en)
        begin
            // drop the head, move the rest up
            for (int i = 0; i < nabp_pkg::FILL_COUNT - 1; i++)
            begin
                window[i] <= window[i + 1];
            end
            window[nabp_pkg::FILL_COUNT - 1] <= sample_in;
        end
    end

    assign head_sample = window[0];

endmodule

// File: source/nabp_shifter.sv
`timescale 1ns/100ps

module nabp_shifter (
    input  logic clk,
    input  logic reset_n,
    nabp_ctrl_if.shifter ctrl,
    output logic shift_en,
    output logic pixel_valid
);

    logic [nabp_pkg::STATE_WIDTH-1:0] state;
    logic [nabp_pkg::STATE_WIDTH-1:0] next_state;
    logic [nabp_pkg::FILL_CNT_WIDTH-1:0] fill_cnt;
    logic [nabp_pkg::SHIFT_CNT_WIDTH-1:0] shift_cnt;
    nabp_pkg::accu_word_u accu;
    nabp_pkg::accu_word_u accu_new;

    // last cycle of each phase
    assign ctrl.fill_done = (state == nabp_pkg::SH_FILL)
        && (fill_cnt == nabp_pkg::FILL_CNT_WIDTH'(1));
    assign ctrl.shift_done = (state == nabp_pkg::SH_SHIFT) && (shift_cnt == '0);

    // wraps freely, only integer crossings matter
    assign accu_new.raw = accu.raw + ctrl.accu_base.raw;

    always_comb
    begin
        next_state = state;
        case (state)
            nabp_pkg::SH_READY:
                if (ctrl.fill_kick)
                    next_state = nabp_pkg::SH_FILL;
            nabp_pkg::SH_FILL:
                if (ctrl.fill_done)
                    next_state = nabp_pkg::SH_FILL_DONE;
            nabp_pkg::SH_FILL_DONE:
                if (ctrl.shift_kick)
                    next_state = nabp_pkg::SH_SHIFT;
            default:
                if (ctrl.shift_done)
                    next_state = nabp_pkg::SH_READY;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
            state <= nabp_pkg::SH_READY;
        else
            state <= next_state;
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            fill_cnt <= '0;
            shift_cnt <= '0;
            shift_en <= 1'b0;
            pixel_valid <= 1'b0;
        end
        else
        begin
            shift_en <= 1'b0;
            pixel_valid <= 1'b0;
            case (state)
                nabp_pkg::SH_READY:
                begin
                    if (ctrl.fill_kick)
                    begin
                        fill_cnt <= nabp_pkg::FILL_CNT_WIDTH'(nabp_pkg::FILL_COUNT);
                        shift_en <= 1'b1;
                    end
                end
                nabp_pkg::SH_FILL:
                begin
                    if (!ctrl.fill_done)
                    begin
                        fill_cnt <= fill_cnt - 1'b1;
                        shift_en <= 1'b1;
                    end
                end
                nabp_pkg::SH_FILL_DONE:
                begin
                    // pixel 0 never shifts
                    if (ctrl.shift_kick)
                    begin
                        shift_cnt <= nabp_pkg::SHIFT_CNT_WIDTH'(nabp_pkg::IMAGE_SIZE - 1);
                        pixel_valid <= 1'b1;
                    end
                end
                default:
                begin
                    if (!ctrl.shift_done)
                    begin
                        shift_cnt <= shift_cnt - 1'b1;
                        pixel_valid <= 1'b1;
                        shift_en <= accu_new.fields.int_part != accu.fields.int_part;
                    end
                end
            endcase
        end
    end

    // accu holds k*step during pixel k
    always_ff @(posedge clk)
    begin
        if (state == nabp_pkg::SH_FILL_DONE)
            accu.raw <= '0;
        else if (state == nabp_pkg::SH_SHIFT)
            accu <= accu_new;
    end

endmodule

// File: source/nabp_state_control.sv
`timescale 1ns/100ps

module nabp_state_control (
    input  logic clk,
    input  logic reset_n,
    input  logic start,
    input  logic [nabp_pkg::ACCU_WIDTH-1:0] step,
    output logic busy,
    output logic line_done,
    nabp_ctrl_if.controller ctrl
);

    logic [nabp_pkg::STATE_WIDTH-1:0] state;
    logic accept;

    // start only counts while idle
    assign accept = start && !busy;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= nabp_pkg::CTRL_IDLE;
            busy <= 1'b0;
            line_done <= 1'b0;
            ctrl.fill_kick <= 1'b0;
            ctrl.shift_kick <= 1'b0;
        end
        else
        begin
            // kicks and line_done are single-cycle pulses
            ctrl.fill_kick <= 1'b0;
            ctrl.shift_kick <= 1'b0;
            line_done <= 1'b0;
            case (state)
                nabp_pkg::CTRL_IDLE, nabp_pkg::CTRL_FINISHING:
                begin
                    if (accept)
                    begin
                        state <= nabp_pkg::CTRL_FILLING;
                        busy <= 1'b1;
                        ctrl.fill_kick <= 1'b1;
                    end
                    else
                    begin
                        state <= nabp_pkg::CTRL_IDLE;
                    end
                end
                nabp_pkg::CTRL_FILLING:
                begin
                    if (ctrl.fill_done)
                    begin
                        state <= nabp_pkg::CTRL_SHIFTING;
                        ctrl.shift_kick <= 1'b1;
                    end
                end
                default:
                begin
                    // shifting, wait for the last pixel
                    if (ctrl.shift_done)
                    begin
                        state <= nabp_pkg::CTRL_FINISHING;
                        busy <= 1'b0;
                        line_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    // only the fraction of the step is used
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            ctrl.accu_base.fields.int_part <= '0;
            ctrl.accu_base.fields.frac_part <= step[nabp_pkg::ACCU_FRAC_BITS-1:0];
        end
    end

endmodule

// File: source/nabp_ctrl_if.sv
`timescale 1ns/100ps

interface nabp_ctrl_if;

    // controller to shifter
    logic fill_kick;
    logic shift_kick;
    nabp_pkg::accu_word_u accu_base;

    // shifter to controller, one-cycle pulses in the last phase cycle
    logic fill_done;
    logic shift_done;

    modport controller (
        output fill_kick,
        output shift_kick,
        output accu_base,
        input  fill_done,
        input  shift_done
    );

    modport shifter (
        input  fill_kick,
        input  shift_kick,
        input  accu_base,
        output fill_done,
        output shift_done
    );

endinterface

// File: source/nabp_pkg.sv
package nabp_pkg;

    // line geometry
    localparam int IMAGE_SIZE = 8;
    localparam int FILL_COUNT = 4;

    // data widths
    localparam int SAMPLE_WIDTH = 8;
    localparam int PIXEL_WIDTH = 16;
    localparam int PIXEL_ADDR_WIDTH = $clog2(IMAGE_SIZE);

    // fixed-point step accumulator, 4.8
    localparam int ACCU_INT_BITS = 4;
    localparam int ACCU_FRAC_BITS = 8;
    localparam int ACCU_WIDTH = ACCU_INT_BITS + ACCU_FRAC_BITS;

    // shifter counters
    localparam int FILL_CNT_WIDTH = $clog2(FILL_COUNT + 1);
    localparam int SHIFT_CNT_WIDTH = $clog2(IMAGE_SIZE);

    // fsm encodings
    localparam int STATE_WIDTH = 2;
    localparam logic [STATE_WIDTH-1:0] CTRL_IDLE = 2'd0;
    localparam logic [STATE_WIDTH-1:0] CTRL_FILLING = 2'd1;
    localparam logic [STATE_WIDTH-1:0] CTRL_SHIFTING = 2'd2;
    localparam logic [STATE_WIDTH-1:0] CTRL_FINISHING = 2'd3;
    localparam logic [STATE_WIDTH-1:0] SH_READY = 2'd0;
    localparam logic [STATE_WIDTH-1:0] SH_FILL = 2'd1;
    localparam logic [STATE_WIDTH-1:0] SH_FILL_DONE = 2'd2;
    localparam logic [STATE_WIDTH-1:0] SH_SHIFT = 2'd3;

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic [PIXEL_ADDR_WIDTH-1:0] pixel_addr_t;

    // raw word for the adder, split fields for the boundary check
    typedef union packed {
        logic [ACCU_WIDTH-1:0] raw;
        struct packed {
            logic [ACCU_INT_BITS-1:0] int_part;
            logic [ACCU_FRAC_BITS-1:0] frac_part;
        } fields;
    } accu_word_u;

endpackage
